// File: hw/video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal geometry in character slots
`define HDISP 8
`define HSYNC_START 9
`define HSYNC_END 11
`define HTOTAL 12

// Vertical geometry
`define ROWS_PER_CHAR 8
`define VDISP 2
// First two scan rows of this character row carry vSync
`define VSYNC_ROW 2
`define VTOTAL 3

// Phases inside the eight-cycle character slot
`define PHASE_VIDEO 0
`define PHASE_PROC 4
`define PHASE_CHAR 7

// Address widths
`define RAM_AW 15
`define FRAME_AW 14

`endif

// File: hw/video_pkg.sv
`include "video_defines.svh"

package videoPkg;

	// One processor write into video RAM
	typedef struct packed {
		logic [`RAM_AW-1:0] address;
		logic [7:0] data;
	} ramWrite_t;

	// One addressable-latch bit update
	typedef struct packed {
		logic [2:0] index;
		logic value;
	} latchWrite_t;

	// Character position from the display sequencer
	typedef struct packed {
		logic [`FRAME_AW-1:0] frameAddr;
		logic [2:0] rowAddr;
		logic displayEn;
	} crtcPos_t;

	// One-cycle strobes within the character slot
	typedef struct packed {
		logic videoTurn;
		logic procTurn;
		logic charEnd;
	} slotStrobes_t;

	// Monochrome pixel stream with its timing flags
	typedef struct packed {
		logic [2:0] rgb;
		logic hSync;
		logic vSync;
		logic blank;
	} pixelOut_t;

endpackage

// File: hw/slotTimer.sv
`include "video_defines.svh"

module slotTimer (
	input  logic PIXELCLK,
	input  logic rst,
	output videoPkg::slotStrobes_t strobes
);

	localparam logic [2:0] VIDEO_PHASE = 3'(`PHASE_VIDEO);
	localparam logic [2:0] PROC_PHASE = 3'(`PHASE_PROC);
	localparam logic [2:0] CHAR_PHASE = 3'(`PHASE_CHAR);

	logic [2:0] phase;

	// Free-running phase, wraps every eight pixels
	always_ff @(posedge PIXELCLK) begin
		if (rst) begin
			phase <= 3'd0;
		end else begin
			phase <= phase + 3'd1;
		end
	end

	// Video RAM turn comes first in the slot
	assign strobes.videoTurn = (phase == VIDEO_PHASE);

	// Processor turn halfway through
	assign strobes.procTurn = (phase == PROC_PHASE);

	// Last pixel of the character, sequencer steps here
	assign strobes.charEnd = (phase == CHAR_PHASE);

endmodule

// File: hw/crtcSequencer.sv
`include "video_defines.svh"

module crtcSequencer (
	input  logic PIXELCLK,
	input  logic rst,
	input  videoPkg::slotStrobes_t strobes,
	input  logic [`FRAME_AW-1:0] screenStart,
	output videoPkg::crtcPos_t pos,
	output logic hSync,
	output logic vSync
);

	typedef enum logic [1:0] {
		activeLine,
		hBorder,
		hSyncPulse,
		vRetrace
	} crtcState_t;

	localparam logic [3:0] LAST_DISP_COL = 4'(`HDISP - 1);
	localparam logic [3:0] PRE_SYNC_COL = 4'(`HSYNC_START - 1);
	localparam logic [3:0] LAST_SYNC_COL = 4'(`HSYNC_END - 1);
	localparam logic [3:0] LAST_COL = 4'(`HTOTAL - 1);
	localparam logic [2:0] LAST_SCAN = 3'(`ROWS_PER_CHAR - 1);
	localparam logic [1:0] LAST_ROW = 2'(`VTOTAL - 1);
	localparam logic [1:0] DISP_ROWS = 2'(`VDISP);
	localparam logic [1:0] SYNC_ROW = 2'(`VSYNC_ROW);
	localparam logic [`FRAME_AW-1:0] ROW_STEP = `HDISP;

	crtcState_t state;
	crtcState_t nextState;
	logic [3:0] column;
	logic [2:0] scanRow;
	logic [1:0] charRow;
	logic [`FRAME_AW-1:0] rowStart;
	logic vSyncLine;
	logic lineEnd;
	logic lastScan;
	logic lastRow;
	logic [2:0] nextScan;
	logic [1:0] nextRow;

	assign lineEnd = (column == LAST_COL);
	assign lastScan = (scanRow == LAST_SCAN);
	assign lastRow = (charRow == LAST_ROW);
	assign nextScan = lastScan ? 3'd0 : scanRow + 3'd1;
	assign nextRow = lastScan ? (lastRow ? 2'd0 : charRow + 2'd1) : charRow;

	// Blank rows reuse vRetrace for their visible columns
	always_comb begin
		nextState = state;
		case (state)
			activeLine, vRetrace: begin
				if (column == LAST_DISP_COL) begin
					nextState = hBorder;
				end
			end
			hBorder: begin
				if (column == PRE_SYNC_COL) begin
					nextState = hSyncPulse;
				end else if (lineEnd) begin
					nextState = (nextRow < DISP_ROWS) ? activeLine : vRetrace;
				end
			end
			hSyncPulse: begin
				if (column == LAST_SYNC_COL) begin
					nextState = hBorder;
				end
			end
			default: nextState = activeLine;
		endcase
	end

	always_ff @(posedge PIXELCLK) begin
		if (rst) begin
			state <= activeLine;
			column <= 4'd0;
			scanRow <= 3'd0;
			charRow <= 2'd0;
			rowStart <= screenStart;
			vSyncLine <= 1'b0;
		end else if (strobes.charEnd) begin
			state <= nextState;
			if (lineEnd) begin
				column <= 4'd0;
				scanRow <= nextScan;
				charRow <= nextRow;
				// vSync covers whole lines, first two scans of the sync row
				vSyncLine <= (nextRow == SYNC_ROW) && (nextScan < 3'd2);
				if (lastScan) begin
					rowStart <= lastRow ? screenStart : rowStart + ROW_STEP;
				end
			end else begin
				column <= column + 4'd1;
			end
		end
	end

	// Wraps modulo the framestore size
	assign pos.frameAddr = rowStart + {{(`FRAME_AW - 4){1'b0}}, column};
	assign pos.rowAddr = scanRow;
	assign pos.displayEn = (state == activeLine);

	assign hSync = (state == hSyncPulse);
	assign vSync = vSyncLine;

endmodule

// File: hw/screenAddressMapper.sv
`include "video_defines.svh"

module screenAddressMapper (
	input  logic PIXELCLK,
	input  logic rst,
	input  videoPkg::latchWrite_t latchWr,
	input  logic latchValid,
	input  videoPkg::crtcPos_t pos,
	output logic [`RAM_AW-1:0] vAddr
);

	logic [7:0] latchBits;
	logic [1:0] sizeCode;
	logic [3:0] wrapAdd;
	logic [3:0] corrected;

	// Addressable latch, one bit per write
	always_ff @(posedge PIXELCLK) begin
		if (rst) begin
			latchBits <= 8'h00;
		end else if (latchValid) begin
			latchBits[latchWr.index] <= latchWr.value;
		end
	end

	// Screen size bits pick the wraparound offset
	assign sizeCode = latchBits[5:4];

	always_comb begin
		case (sizeCode)
			2'd0: wrapAdd = 4'd8;
			2'd1: wrapAdd = 4'd12;
			2'd2: wrapAdd = 4'd6;
			default: wrapAdd = 4'd11;
		endcase
	end

	// Only addresses past the top of RAM get folded back
	assign corrected = pos.frameAddr[12] ? pos.frameAddr[11:8] + wrapAdd
		: pos.frameAddr[11:8];

	// Graphics mode layout, eight scan rows per character cell
	assign vAddr = {corrected, pos.frameAddr[7:0], pos.rowAddr};

endmodule

// File: hw/requestSlot.sv
module requestSlot #(
	parameter type payload_t = logic [7:0]
) (
	input  logic PIXELCLK,
	input  logic rst,
	input  logic inValid,
	output logic inReady,
	input  payload_t inData,
	input  logic drain,
	output logic outValid,
	output payload_t outData
);

	logic full;
	payload_t held;
	logic accept;

	assign accept = inValid && !full;

	// Ready only while empty
	assign inReady = ~full;

	// Item goes out in the same cycle the slot clears
	assign outValid = full & drain;
	assign outData = held;

	always_ff @(posedge PIXELCLK) begin
		if (rst) begin
			full <= 1'b0;
		end else if (accept) begin
			full <= 1'b1;
		end else if (drain) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (accept) begin
			held <= inData;
		end
	end

endmodule

// File: hw/videoRam.sv
`include "video_defines.svh"

module videoRam (
	input  logic PIXELCLK,
	input  videoPkg::slotStrobes_t strobes,
	input  videoPkg::ramWrite_t wr,
	input  logic wrValid,
	input  logic [`RAM_AW-1:0] vAddr,
	output logic [7:0] vData
);

	localparam int DEPTH = 1 << `RAM_AW;

	logic [7:0] mem [0:DEPTH-1];

	// Processor side only gets the RAM at its own turn
	always_ff @(posedge PIXELCLK) begin
		if (strobes.procTurn && wrValid) begin
			mem[wr.address] <= wr.data;
		end
	end

	// Video fetch, byte ready for the shifter one cycle later
	always_ff @(posedge PIXELCLK) begin
		if (strobes.videoTurn) begin
			vData <= mem[vAddr];
		end
	end

endmodule

// File: hw/pixelShifter.sv
module pixelShifter (
	input  logic PIXELCLK,
	input  logic rst,
	input  videoPkg::slotStrobes_t strobes,
	input  logic [7:0] vData,
	input  logic displayEn,
	input  logic hSync,
	input  logic vSync,
	output videoPkg::pixelOut_t video
);

	logic loadNow;
	logic [7:0] shiftReg;
	logic hSyncD;
	logic vSyncD;
	logic blankD;

	always_ff @(posedge PIXELCLK) begin
		if (rst) begin
			loadNow <= 1'b0;
			shiftReg <= 8'h00;
			hSyncD <= 1'b0;
			vSyncD <= 1'b0;
			blankD <= 1'b1;
		end else begin
			// Phase 1, the cycle after the video read
			loadNow <= strobes.videoTurn;
			if (loadNow) begin
				shiftReg <= displayEn ? vData : 8'h00;
				// Flags held a full character to match the pixels
				hSyncD <= hSync;
				vSyncD <= vSync;
				blankD <= ~displayEn;
			end else begin
				shiftReg <= {shiftReg[6:0], 1'b0};
			end
		end
	end

	// MSB first, white or black
	assign video.rgb = {3{shiftReg[7]}};
	assign video.hSync = hSyncD;
	assign video.vSync = vSyncD;
	assign video.blank = blankD;

endmodule

// File: hw/videoSubsystem.sv
`include "video_defines.svh"

module videoSubsystem (
	input  logic PIXELCLK,
	input  logic rst,
	input  videoPkg::ramWrite_t ramWrIn,
	input  logic ramWrValid,
	output logic ramWrReady,
	input  videoPkg::latchWrite_t latchWrIn,
	input  logic latchWrValid,
	output logic latchWrReady,
	input  logic [`FRAME_AW-1:0] screenStart,
	output videoPkg::pixelOut_t video
);

	videoPkg::slotStrobes_t strobes;
	videoPkg::crtcPos_t pos;
	videoPkg::ramWrite_t ramWr;
	videoPkg::latchWrite_t latchWr;
	logic crtcHSync;
	logic crtcVSync;
	logic ramWrGo;
	logic latchGo;
	logic [`RAM_AW-1:0] vAddr;
	logic [7:0] vData;

	slotTimer timer (
		.PIXELCLK(PIXELCLK),
		.rst(rst),
		.strobes(strobes)
	);

	crtcSequencer crtc (
		.PIXELCLK(PIXELCLK),
		.rst(rst),
		.strobes(strobes),
		.screenStart(screenStart),
		.pos(pos),
		.hSync(crtcHSync),
		.vSync(crtcVSync)
	);

	// Processor writes wait here for the processor turn
	requestSlot #(.payload_t(videoPkg::ramWrite_t)) ramWrSlot (
		.PIXELCLK(PIXELCLK),
		.rst(rst),
		.inValid(ramWrValid),
		.inReady(ramWrReady),
		.inData(ramWrIn),
		.drain(strobes.procTurn),
		.outValid(ramWrGo),
		.outData(ramWr)
	);

	requestSlot #(.payload_t(videoPkg::latchWrite_t)) latchWrSlot (
		.PIXELCLK(PIXELCLK),
		.rst(rst),
		.inValid(latchWrValid),
		.inReady(latchWrReady),
		.inData(latchWrIn),
		.drain(strobes.procTurn),
		.outValid(latchGo),
		.outData(latchWr)
	);

	screenAddressMapper mapper (
		.PIXELCLK(PIXELCLK),
		.rst(rst),
		.latchWr(latchWr),
		.latchValid(latchGo),
		.pos(pos),
		.vAddr(vAddr)
	);

	videoRam ram (
		.PIXELCLK(PIXELCLK),
		.strobes(strobes),
		.wr(ramWr),
		.wrValid(ramWrGo),
		.vAddr(vAddr),
		.vData(vData)
	);

	pixelShifter shifter (
		.PIXELCLK(PIXELCLK),
		.rst(rst),
		.strobes(strobes),
		.vData(vData),
		.displayEn(pos.displayEn),
		.hSync(crtcHSync),
		.vSync(crtcVSync),
		.video(video)
	);

endmodule

// File: sim/videoSubsystem_checker.sv
module videoSubsystem_checker (
	input logic PIXELCLK,
	input logic rst,
	input videoPkg::ramWrite_t ramWrIn,
	input logic ramWrValid,
	input logic ramWrReady,
	input videoPkg::latchWrite_t latchWrIn,
	input logic latchWrValid,
	input logic latchWrReady,
	input videoPkg::pixelOut_t video
);

	// Two characters of eight pixels
	localparam int HSYNC_MAX = 16;

	int hSyncRun;

	always_ff @(posedge PIXELCLK) begin
		if (rst || !video.hSync) begin
			hSyncRun <= 0;
		end else begin
			hSyncRun <= hSyncRun + 1;
		end
	end

	// Stalled offers keep their payload
	ramPayloadHeld: assert property (@(posedge PIXELCLK) disable iff (rst)
		ramWrValid && !ramWrReady |=> $stable(ramWrIn))
		else $error("RAM write payload changed while stalled");

	latchPayloadHeld: assert property (@(posedge PIXELCLK) disable iff (rst)
		latchWrValid && !latchWrReady |=> $stable(latchWrIn))
		else $error("Latch write payload changed while stalled");

	hSyncWidth: assert property (@(posedge PIXELCLK) disable iff (rst) hSyncRun <= HSYNC_MAX)
		else $error("hSync longer than two characters");

	blankInVSync: assert property (@(posedge PIXELCLK) disable iff (rst)
		video.vSync |-> video.blank)
		else $error("Visible pixels during vSync");

endmodule

bind videoSubsystem videoSubsystem_checker rules (
	.PIXELCLK(PIXELCLK),
	.rst(rst),
	.ramWrIn(ramWrIn),
	.ramWrValid(ramWrValid),
	.ramWrReady(ramWrReady),
	.latchWrIn(latchWrIn),
	.latchWrValid(latchWrValid),
	.latchWrReady(latchWrReady),
	.video(video)
);

// File: sim/videoSubsystem_tb.sv
`include "video_defines.svh"

module videoSubsystem_tb;

	localparam int TIMEOUT = 6000;
	localparam int PIX_PER_LINE = `HDISP * 8;
	localparam int LINES = `VDISP * `ROWS_PER_CHAR;
	localparam int FRAME_BYTES = LINES * `HDISP;

	typedef logic [`FRAME_AW-1:0] frameAddr_t;

	typedef struct packed {
		frameAddr_t start;
		logic [1:0] sizeCode;
		logic [7:0] writes;
	} testEntry_t;

	// Screen start, screen size code, random bytes to write
	localparam testEntry_t TESTS [5] = '{
		'{14'h0300, 2'd0, 8'd128},
		'{14'h1200, 2'd0, 8'd128},
		'{14'h1A40, 2'd1, 8'd140},
		'{14'h0FF8, 2'd2, 8'd150},
		'{14'h3E10, 2'd3, 8'd160}
	};

	// Page offset per size code once an address runs past the top of RAM
	localparam logic [3:0] WRAP_ADD [4] = '{4'd8, 4'd12, 4'd6, 4'd11};

	logic PIXELCLK;
	logic rst;
	videoPkg::ramWrite_t ramWrIn;
	logic ramWrValid;
	logic ramWrReady;
	videoPkg::latchWrite_t latchWrIn;
	logic latchWrValid;
	logic latchWrReady;
	frameAddr_t screenStart;
	videoPkg::pixelOut_t video;

	logic [7:0] mirror [0:(1 << `RAM_AW) - 1];
	int testErrors;
	int passed;
	int failed;

	videoSubsystem uut (
		.PIXELCLK(PIXELCLK),
		.rst(rst),
		.ramWrIn(ramWrIn),
		.ramWrValid(ramWrValid),
		.ramWrReady(ramWrReady),
		.latchWrIn(latchWrIn),
		.latchWrValid(latchWrValid),
		.latchWrReady(latchWrReady),
		.screenStart(screenStart),
		.video(video)
	);

	initial begin
		PIXELCLK = 1'b0;
		forever #50 PIXELCLK = ~PIXELCLK;
	end

	// RAM address of the idx-th displayed byte, in scan order
	function automatic logic [`RAM_AW-1:0] displayedAddr(input int idx, input frameAddr_t start,
		input logic [1:0] code);
		int line;
		frameAddr_t fa;
		logic [3:0] page;
		line = idx / `HDISP;
		fa = start + frameAddr_t'((line / `ROWS_PER_CHAR) * `HDISP + idx % `HDISP);
		page = fa[11:8];
		if (fa[12]) begin
			page = page + WRAP_ADD[code];
		end
		return {page, fa[7:0], 3'(line % `ROWS_PER_CHAR)};
	endfunction

	task automatic checkValue(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			testErrors++;
		end
	endtask

	// Hold an offer on one write port until the slot takes it
	task automatic offerWrite(input logic toLatch, input logic [`RAM_AW-1:0] addr,
		input logic [7:0] data);
		int waited;
		waited = 0;
		if (toLatch) begin
			latchWrIn.index = addr[2:0];
			latchWrIn.value = data[0];
			latchWrValid = 1'b1;
		end else begin
			ramWrIn.address = addr;
			ramWrIn.data = data;
			ramWrValid = 1'b1;
		end
		while (!(toLatch ? latchWrReady : ramWrReady) && waited < TIMEOUT) begin
			@(negedge PIXELCLK);
			waited++;
		end
		if (!(toLatch ? latchWrReady : ramWrReady)) begin
			$display("Write offer to %h was never accepted", addr);
			testErrors++;
		end else if (!toLatch) begin
			mirror[addr] = data;
		end
		@(negedge PIXELCLK);
	endtask

	task automatic waitVSync(input logic level);
		int waited;
		waited = 0;
		while (video.vSync !== level && waited < TIMEOUT) begin
			@(negedge PIXELCLK);
			waited++;
		end
		if (video.vSync !== level) begin
			$display("vSync never went to %0b", level);
			testErrors++;
		end
	endtask

	// One frame from the fall of vSync, every visible pixel against the mirror
	task automatic checkFrame(input frameAddr_t start, input logic [1:0] code);
		int waited;
		int n;
		int linePixels;
		int lines;
		logic prevHSync;
		logic [7:0] expByte;
		logic [2:0] expRgb;
		waited = 0;
		n = 0;
		linePixels = 0;
		lines = 0;
		waitVSync(1'b1);
		waitVSync(1'b0);
		prevHSync = video.hSync;
		while (!video.vSync && waited < TIMEOUT) begin
			if (!video.blank) begin
				expByte = mirror[displayedAddr((n / 8) % FRAME_BYTES, start, code)];
				expRgb = expByte[3'(7 - n % 8)] ? 3'b111 : 3'b000;
				if (video.rgb !== expRgb) begin
					$display("FAILED at %0t: video.rgb = %b, expected %b (pixel %0d)",
						$time, video.rgb, expRgb, n);
					testErrors++;
				end
				n++;
				linePixels++;
			end
			if (video.hSync && !prevHSync && linePixels > 0) begin
				checkValue("pixels per line", linePixels, PIX_PER_LINE);
				lines++;
				linePixels = 0;
			end
			prevHSync = video.hSync;
			@(negedge PIXELCLK);
			waited++;
		end
		if (!video.vSync) begin
			$display("Frame did not end within %0d cycles", TIMEOUT);
			testErrors++;
		end
		checkValue("lines with pixels", lines, LINES);
		checkValue("visible pixels", n, LINES * PIX_PER_LINE);
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s, %0d errors", name, testErrors);
			failed++;
		end
		testErrors = 0;
	endtask

	initial begin
		int i;
		int k;
		void'($urandom(6378));
		rst = 1'b1;
		ramWrIn = '0;
		ramWrValid = 1'b0;
		latchWrIn = '0;
		latchWrValid = 1'b0;
		screenStart = TESTS[0].start;
		testErrors = 0;
		passed = 0;
		failed = 0;
		repeat (5) @(posedge PIXELCLK);
		@(negedge PIXELCLK);
		rst = 1'b0;
		checkValue("ramWrReady", ramWrReady, 1);
		checkValue("latchWrReady", latchWrReady, 1);
		checkValue("video.blank", video.blank, 1);
		checkValue("video.hSync", video.hSync, 0);
		checkValue("video.vSync", video.vSync, 0);
		checkValue("video.rgb", video.rgb, 0);
		finishTest("reset state");
		for (i = 0; i < 5; i++) begin
			screenStart = TESTS[i].start;
			// Size code lives in latch bits 4 and 5
			offerWrite(1'b1, 15'd4, {7'd0, TESTS[i].sizeCode[0]});
			offerWrite(1'b1, 15'd5, {7'd0, TESTS[i].sizeCode[1]});
			latchWrValid = 1'b0;
			// Valid stays high between offers, so most of these meet a full slot
			for (k = 0; k < int'(TESTS[i].writes); k++) begin
				offerWrite(1'b0, displayedAddr(k % FRAME_BYTES, TESTS[i].start,
					TESTS[i].sizeCode), 8'($urandom));
			end
			ramWrValid = 1'b0;
			checkFrame(TESTS[i].start, TESTS[i].sizeCode);
			finishTest($sformatf("frame at %h, size code %0d", TESTS[i].start,
				TESTS[i].sizeCode));
		end
		$display("Tests: %0d passed, %0d failed", passed, failed);
		if (failed == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/video_pkg.sv
hw/slotTimer.sv
hw/crtcSequencer.sv
hw/screenAddressMapper.sv
hw/requestSlot.sv
hw/videoRam.sv
hw/pixelShifter.sv
hw/videoSubsystem.sv
sim/videoSubsystem_checker.sv
sim/videoSubsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the failure message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module videoSubsystem_tb \
	-f verilog.f -o simv > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
